/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_amber_bus
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* hw/amber_bus_pkg.sv */
// Shared definitions for the two-master Wishbone bus fabric
// Bus widths, slave map, peripheral register offsets and the
// address view used by the decoder and the peripherals
package amber_bus_pkg;

    // ----------------------------------------------------------------------
    // Bus widths
    // ----------------------------------------------------------------------
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;
    localparam int WB_AWIDTH = 32;

    // Slave index lives in address bits 31:28
    localparam int SLV_IDX_W = 4;
    localparam logic [SLV_IDX_W-1:0] SLV_BOOT_MEM = 4'd0;
    localparam logic [SLV_IDX_W-1:0] SLV_TIMER    = 4'd1;
    localparam logic [SLV_IDX_W-1:0] SLV_IRQ_CTRL = 4'd2;

    // Boot memory, cut down to 256 words
    localparam int BOOT_MEM_WORDS = 256;
    localparam int BOOT_MEM_AW    = $clog2(BOOT_MEM_WORDS);

    // ----------------------------------------------------------------------
    // Register word offsets, address bits 11:2
    // ----------------------------------------------------------------------
    localparam int OFFSET_W = 10;
    localparam logic [OFFSET_W-1:0] TIMER_LOAD  = 10'd0;
    localparam logic [OFFSET_W-1:0] TIMER_VALUE = 10'd1;
    localparam logic [OFFSET_W-1:0] TIMER_CTRL  = 10'd2;
    localparam logic [OFFSET_W-1:0] TIMER_CLEAR = 10'd3;

    localparam logic [OFFSET_W-1:0] IRQ_STATUS       = 10'd0;
    localparam logic [OFFSET_W-1:0] IRQ_RAW          = 10'd1;
    localparam logic [OFFSET_W-1:0] IRQ_ENABLE_SET   = 10'd2;
    localparam logic [OFFSET_W-1:0] IRQ_ENABLE_CLEAR = 10'd3;

    // Bit 0 timer, bits 2:1 external lines
    localparam int IRQ_SRC_W = 3;

    // One address word, seen whole or split into fields
    typedef union packed {
        logic [WB_AWIDTH-1:0] word;
        struct packed {
            logic [SLV_IDX_W-1:0] slv_idx;
            logic [15:0]          unused;
            logic [OFFSET_W-1:0]  offset;
            logic [1:0]           byte_off;
        } fields;
    } bus_addr_u;

endpackage

/* hw/amber_bus_top.sv */
// Bus fabric top level
// Two masters through the arbiter and decoder to boot memory,
// timer and interrupt controller
`timescale 1ns/1ps

module amber_bus_top import amber_bus_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    // Master 0
    input  logic [WB_AWIDTH-1:0] i_m0_adr,
    input  logic [WB_SWIDTH-1:0] i_m0_sel,
    input  logic                 i_m0_we,
    input  logic [WB_DWIDTH-1:0] i_m0_dat,
    input  logic                 i_m0_cyc,
    input  logic                 i_m0_stb,
    output logic [WB_DWIDTH-1:0] o_m0_dat,
    output logic                 o_m0_ack,
    output logic                 o_m0_err,
    // Master 1
    input  logic [WB_AWIDTH-1:0] i_m1_adr,
    input  logic [WB_SWIDTH-1:0] i_m1_sel,
    input  logic                 i_m1_we,
    input  logic [WB_DWIDTH-1:0] i_m1_dat,
    input  logic                 i_m1_cyc,
    input  logic                 i_m1_stb,
    output logic [WB_DWIDTH-1:0] o_m1_dat,
    output logic                 o_m1_ack,
    output logic                 o_m1_err,
    // Interrupts
    input  logic [IRQ_SRC_W-2:0] i_ext_irq,
    output logic                 o_irq
);

    // Arbiter to decoder
    logic [WB_AWIDTH-1:0] s_adr;
    logic [WB_SWIDTH-1:0] s_sel;
    logic                 s_we;
    logic [WB_DWIDTH-1:0] s_wdat;
    logic                 s_stb;
    logic [WB_DWIDTH-1:0] s_rdat;
    logic                 s_ack;
    logic                 s_err;

    // Decoder to peripherals
    logic [WB_AWIDTH-1:0] slv_adr;
    logic [WB_SWIDTH-1:0] slv_sel;
    logic                 slv_we;
    logic [WB_DWIDTH-1:0] slv_wdat;
    logic                 mem_stb, tmr_stb, irq_stb;
    logic                 mem_ack, tmr_ack, irq_ack;
    logic [WB_DWIDTH-1:0] mem_rdat, tmr_rdat, irq_rdat;
    logic                 timer_int;

    // ----------------------------------------------------------------------
    // Arbitration and decode
    // ----------------------------------------------------------------------
    wb_arbiter u_wb_arbiter (
        .i_clk    (i_clk),    .i_arst_n (i_arst_n),
        .i_m0_adr (i_m0_adr), .i_m0_sel (i_m0_sel), .i_m0_we  (i_m0_we),
        .i_m0_dat (i_m0_dat), .i_m0_cyc (i_m0_cyc), .i_m0_stb (i_m0_stb),
        .o_m0_dat (o_m0_dat), .o_m0_ack (o_m0_ack), .o_m0_err (o_m0_err),
        .i_m1_adr (i_m1_adr), .i_m1_sel (i_m1_sel), .i_m1_we  (i_m1_we),
        .i_m1_dat (i_m1_dat), .i_m1_cyc (i_m1_cyc), .i_m1_stb (i_m1_stb),
        .o_m1_dat (o_m1_dat), .o_m1_ack (o_m1_ack), .o_m1_err (o_m1_err),
        .o_s_adr  (s_adr),    .o_s_sel  (s_sel),    .o_s_we   (s_we),
        .o_s_dat  (s_wdat),   .o_s_stb  (s_stb),
        .i_s_dat  (s_rdat),   .i_s_ack  (s_ack),    .i_s_err  (s_err)
    );

    wb_slave_decoder u_wb_slave_decoder (
        .i_clk     (i_clk),   .i_arst_n  (i_arst_n),
        .i_adr     (s_adr),   .i_sel     (s_sel),   .i_we      (s_we),
        .i_dat     (s_wdat),  .i_stb     (s_stb),
        .o_dat     (s_rdat),  .o_ack     (s_ack),   .o_err     (s_err),
        .o_slv_adr (slv_adr), .o_slv_sel (slv_sel),
        .o_slv_we  (slv_we),  .o_slv_dat (slv_wdat),
        .o_mem_stb (mem_stb), .i_mem_dat (mem_rdat), .i_mem_ack (mem_ack),
        .o_tmr_stb (tmr_stb), .i_tmr_dat (tmr_rdat), .i_tmr_ack (tmr_ack),
        .o_irq_stb (irq_stb), .i_irq_dat (irq_rdat), .i_irq_ack (irq_ack)
    );

    // ----------------------------------------------------------------------
    // Peripherals
    // ----------------------------------------------------------------------
    boot_mem u_boot_mem (
        .i_clk  (i_clk),    .i_arst_n (i_arst_n),
        .i_adr  (slv_adr),  .i_sel    (slv_sel),  .i_we (slv_we),
        .i_dat  (slv_wdat), .i_stb    (mem_stb),
        .o_dat  (mem_rdat), .o_ack    (mem_ack)
    );

    timer_module u_timer_module (
        .i_clk  (i_clk),    .i_arst_n (i_arst_n),
        .i_adr  (slv_adr),  .i_we     (slv_we),
        .i_dat  (slv_wdat), .i_stb    (tmr_stb),
        .o_dat  (tmr_rdat), .o_ack    (tmr_ack),
        .o_timer_int (timer_int)
    );

    interrupt_controller u_interrupt_controller (
        .i_clk  (i_clk),    .i_arst_n (i_arst_n),
        .i_adr  (slv_adr),  .i_we     (slv_we),
        .i_dat  (slv_wdat), .i_stb    (irq_stb),
        .o_dat  (irq_rdat), .o_ack    (irq_ack),
        .i_timer_int (timer_int),
        .i_ext_irq   (i_ext_irq),
        .o_irq       (o_irq)
    );

endmodule

/* hw/boot_mem.sv */
// Boot memory, 256 words with byte-lane writes
// Registered read data and a single-cycle ack per access
`timescale 1ns/1ps

module boot_mem import amber_bus_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic [WB_AWIDTH-1:0] i_adr,
    input  logic [WB_SWIDTH-1:0] i_sel,
    input  logic                 i_we,
    input  logic [WB_DWIDTH-1:0] i_dat,
    input  logic                 i_stb,
    output logic [WB_DWIDTH-1:0] o_dat,
    output logic                 o_ack
);

    logic [WB_DWIDTH-1:0]   mem [BOOT_MEM_WORDS];
    logic [BOOT_MEM_AW-1:0] word_idx;
    logic                   access;

    // Word address, byte offset dropped
    assign word_idx = i_adr[BOOT_MEM_AW+1:2];

    // First cycle of the strobe only
    assign access = i_stb && !o_ack;

    always_ff @(posedge i_clk) begin
        if (access) begin
            if (i_we) begin
                for (int b = 0; b < WB_SWIDTH; b++) begin
                    if (i_sel[b]) begin
                        mem[word_idx][8*b +: 8] <= i_dat[8*b +: 8];
                    end
                end
            end
            o_dat <= mem[word_idx];
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ack <= 1'b0;
        end else begin
            o_ack <= access;
        end
    end

endmodule

/* hw/interrupt_controller.sv */
// Interrupt controller
// Combines the timer and two external lines into one registered
// processor interrupt through set/clear enable registers
`timescale 1ns/1ps

module interrupt_controller import amber_bus_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic [WB_AWIDTH-1:0] i_adr,
    input  logic                 i_we,
    input  logic [WB_DWIDTH-1:0] i_dat,
    input  logic                 i_stb,
    output logic [WB_DWIDTH-1:0] o_dat,
    output logic                 o_ack,
    input  logic                 i_timer_int,
    input  logic [IRQ_SRC_W-2:0] i_ext_irq,
    output logic                 o_irq
);

    bus_addr_u            adr_u;
    logic                 access;
    logic                 wr_en;
    logic [IRQ_SRC_W-1:0] raw;
    logic [IRQ_SRC_W-1:0] enable_q;
    logic [IRQ_SRC_W-1:0] status;

    assign adr_u.word = i_adr;
    assign access     = i_stb && !o_ack;
    assign wr_en      = access && i_we;

    // Bit 0 timer, upper bits external
    assign raw    = {i_ext_irq, i_timer_int};
    assign status = raw & enable_q;

    // ----------------------------------------------------------------------
    // Enables, ack and the combined interrupt
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            enable_q <= '0;
            o_ack    <= 1'b0;
            o_irq    <= 1'b0;
        end else begin
            o_ack <= access;
            o_irq <= |status;
            // Ones set or clear, zeros leave the bit alone
            if (wr_en && adr_u.fields.offset == IRQ_ENABLE_SET) begin
                enable_q <= enable_q | i_dat[IRQ_SRC_W-1:0];
            end else if (wr_en && adr_u.fields.offset == IRQ_ENABLE_CLEAR) begin
                enable_q <= enable_q & ~i_dat[IRQ_SRC_W-1:0];
            end
        end
    end

    // Both enable offsets read back the enable mask
    always_ff @(posedge i_clk) begin
        if (access) begin
            case (adr_u.fields.offset)
                IRQ_STATUS:       o_dat <= {{(WB_DWIDTH-IRQ_SRC_W){1'b0}}, status};
                IRQ_RAW:          o_dat <= {{(WB_DWIDTH-IRQ_SRC_W){1'b0}}, raw};
                IRQ_ENABLE_SET,
                IRQ_ENABLE_CLEAR: o_dat <= {{(WB_DWIDTH-IRQ_SRC_W){1'b0}}, enable_q};
                default:          o_dat <= '0;
            endcase
        end
    end

endmodule

/* hw/timer_module.sv */
// Reloading down-counter timer
// Counts from the load value to zero, raises a sticky interrupt
// flag and reloads; the flag is cleared through a register write
`timescale 1ns/1ps

module timer_module import amber_bus_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    input  logic [WB_AWIDTH-1:0] i_adr,
    input  logic                 i_we,
    input  logic [WB_DWIDTH-1:0] i_dat,
    input  logic                 i_stb,
    output logic [WB_DWIDTH-1:0] o_dat,
    output logic                 o_ack,
    output logic                 o_timer_int
);

    bus_addr_u            adr_u;
    logic                 access;
    logic                 wr_en;
    logic [WB_DWIDTH-1:0] load_q;
    logic [WB_DWIDTH-1:0] value_q;
    logic                 enable_q;
    logic                 expire;

    assign adr_u.word = i_adr;
    assign access     = i_stb && !o_ack;
    assign wr_en      = access && i_we;
    assign expire     = enable_q && (value_q == '0);

    // ----------------------------------------------------------------------
    // Counter and control registers
    // ----------------------------------------------------------------------
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            load_q      <= '0;
            value_q     <= '0;
            enable_q    <= 1'b0;
            o_timer_int <= 1'b0;
            o_ack       <= 1'b0;
        end else begin
            o_ack <= access;
            // Count down, reload at zero
            if (expire) begin
                value_q <= load_q;
            end else if (enable_q) begin
                value_q <= value_q - 1'b1;
            end
            if (wr_en && adr_u.fields.offset == TIMER_LOAD) begin
                load_q  <= i_dat;
                value_q <= i_dat;
            end
            if (wr_en && adr_u.fields.offset == TIMER_CTRL) begin
                enable_q <= i_dat[0];
            end
            // A new expiry wins over a clear in the same cycle
            if (expire) begin
                o_timer_int <= 1'b1;
            end else if (wr_en && adr_u.fields.offset == TIMER_CLEAR) begin
                o_timer_int <= 1'b0;
            end
        end
    end

    // Read data
    always_ff @(posedge i_clk) begin
        if (access) begin
            case (adr_u.fields.offset)
                TIMER_LOAD:  o_dat <= load_q;
                TIMER_VALUE: o_dat <= value_q;
                TIMER_CTRL:  o_dat <= {{(WB_DWIDTH-1){1'b0}}, enable_q};
                default:     o_dat <= '0;
            endcase
        end
    end

endmodule

/* hw/wb_arbiter.sv */
// Two-master fixed-priority Wishbone arbiter
// Master 0 wins ties; the grant is held until the owner drops cyc
`timescale 1ns/1ps

module wb_arbiter import amber_bus_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    // Master 0
    input  logic [WB_AWIDTH-1:0] i_m0_adr,
    input  logic [WB_SWIDTH-1:0] i_m0_sel,
    input  logic                 i_m0_we,
    input  logic [WB_DWIDTH-1:0] i_m0_dat,
    input  logic                 i_m0_cyc,
    input  logic                 i_m0_stb,
    output logic [WB_DWIDTH-1:0] o_m0_dat,
    output logic                 o_m0_ack,
    output logic                 o_m0_err,
    // Master 1
    input  logic [WB_AWIDTH-1:0] i_m1_adr,
    input  logic [WB_SWIDTH-1:0] i_m1_sel,
    input  logic                 i_m1_we,
    input  logic [WB_DWIDTH-1:0] i_m1_dat,
    input  logic                 i_m1_cyc,
    input  logic                 i_m1_stb,
    output logic [WB_DWIDTH-1:0] o_m1_dat,
    output logic                 o_m1_ack,
    output logic                 o_m1_err,
    // Toward the decoder
    output logic [WB_AWIDTH-1:0] o_s_adr,
    output logic [WB_SWIDTH-1:0] o_s_sel,
    output logic                 o_s_we,
    output logic [WB_DWIDTH-1:0] o_s_dat,
    output logic                 o_s_stb,
    input  logic [WB_DWIDTH-1:0] i_s_dat,
    input  logic                 i_s_ack,
    input  logic                 i_s_err
);

    logic gnt_m0;
    logic gnt_m1;
    logic bus_busy;

    // Owner still holding its cycle
    assign bus_busy = (gnt_m0 && i_m0_cyc) || (gnt_m1 && i_m1_cyc);

    // Grant reloads only when the bus is free
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            gnt_m0 <= 1'b0;
            gnt_m1 <= 1'b0;
        end else if (!bus_busy) begin
            gnt_m0 <= i_m0_cyc;
            gnt_m1 <= i_m1_cyc && !i_m0_cyc;
        end
    end

    // ----------------------------------------------------------------------
    // Forward the owner, the other master just waits
    // ----------------------------------------------------------------------
    assign o_s_adr = gnt_m1 ? i_m1_adr : i_m0_adr;
    assign o_s_sel = gnt_m1 ? i_m1_sel : i_m0_sel;
    assign o_s_we  = gnt_m1 ? i_m1_we  : i_m0_we;
    assign o_s_dat = gnt_m1 ? i_m1_dat : i_m0_dat;
    assign o_s_stb = (gnt_m0 && i_m0_stb) || (gnt_m1 && i_m1_stb);

    // Responses go back to the owner only
    assign o_m0_dat = gnt_m0 ? i_s_dat : '0;
    assign o_m0_ack = gnt_m0 && i_s_ack;
    assign o_m0_err = gnt_m0 && i_s_err;
    assign o_m1_dat = gnt_m1 ? i_s_dat : '0;
    assign o_m1_ack = gnt_m1 && i_s_ack;
    assign o_m1_err = gnt_m1 && i_s_err;

endmodule

/* hw/wb_slave_decoder.sv */
// Slave address decoder
// Routes the granted access to one peripheral by the slave index,
// muxes the read data back and answers unmapped indices with err
`timescale 1ns/1ps

module wb_slave_decoder import amber_bus_pkg::*; (
    input  logic                 i_clk,
    input  logic                 i_arst_n,
    // From the arbiter
    input  logic [WB_AWIDTH-1:0] i_adr,
    input  logic [WB_SWIDTH-1:0] i_sel,
    input  logic                 i_we,
    input  logic [WB_DWIDTH-1:0] i_dat,
    input  logic                 i_stb,
    output logic [WB_DWIDTH-1:0] o_dat,
    output logic                 o_ack,
    output logic                 o_err,
    // Shared slave request lines
    output logic [WB_AWIDTH-1:0] o_slv_adr,
    output logic [WB_SWIDTH-1:0] o_slv_sel,
    output logic                 o_slv_we,
    output logic [WB_DWIDTH-1:0] o_slv_dat,
    // Per-slave strobes and responses
    output logic                 o_mem_stb,
    input  logic [WB_DWIDTH-1:0] i_mem_dat,
    input  logic                 i_mem_ack,
    output logic                 o_tmr_stb,
    input  logic [WB_DWIDTH-1:0] i_tmr_dat,
    input  logic                 i_tmr_ack,
    output logic                 o_irq_stb,
    input  logic [WB_DWIDTH-1:0] i_irq_dat,
    input  logic                 i_irq_ack
);

    bus_addr_u            adr_u;
    logic                 unmapped_stb;
    logic                 err_q;
    logic [SLV_IDX_W-1:0] idx_q;

    assign adr_u.word = i_adr;

    // One strobe per mapped slave
    assign o_mem_stb    = i_stb && (adr_u.fields.slv_idx == SLV_BOOT_MEM);
    assign o_tmr_stb    = i_stb && (adr_u.fields.slv_idx == SLV_TIMER);
    assign o_irq_stb    = i_stb && (adr_u.fields.slv_idx == SLV_IRQ_CTRL);
    assign unmapped_stb = i_stb && !(o_mem_stb || o_tmr_stb || o_irq_stb);

    assign o_slv_adr = i_adr;
    assign o_slv_sel = i_sel;
    assign o_slv_we  = i_we;
    assign o_slv_dat = i_dat;

    // Error path answers like a slave, one pulse per access
    // Index held for the read data mux
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            err_q <= 1'b0;
            idx_q <= '0;
        end else begin
            err_q <= unmapped_stb && !err_q;
            if (i_stb) begin
                idx_q <= adr_u.fields.slv_idx;
            end
        end
    end

    assign o_ack = i_mem_ack || i_tmr_ack || i_irq_ack;
    assign o_err = err_q;

    // Unmapped reads return zero
    always_comb begin
        case (idx_q)
            SLV_BOOT_MEM: o_dat = i_mem_dat;
            SLV_TIMER:    o_dat = i_tmr_dat;
            SLV_IRQ_CTRL: o_dat = i_irq_dat;
            default:      o_dat = '0;
        endcase
    end

endmodule

/* sim.f */
hw/amber_bus_pkg.sv
hw/wb_arbiter.sv
hw/wb_slave_decoder.sv
hw/boot_mem.sv
hw/timer_module.sv
hw/interrupt_controller.sv
hw/amber_bus_top.sv
tests/tb_clk_gen.sv
tests/amber_bus_props.sv
tests/tb_amber_bus.sv

/* tests/amber_bus_props.sv */
// Bus protocol checks on the slave decoder
// Response exclusivity, ack causality and one-hot slave strobes
`timescale 1ns/1ps

module amber_bus_props import amber_bus_pkg::*; (
    input logic                 i_clk,
    input logic                 i_arst_n,
    input logic [WB_AWIDTH-1:0] i_adr,
    input logic                 i_stb,
    input logic                 i_ack,
    input logic                 i_err,
    input logic                 i_mem_stb,
    input logic                 i_tmr_stb,
    input logic                 i_irq_stb
);

    bus_addr_u adr_u;
    logic      mapped;

    assign adr_u.word = i_adr;
    // Index hits one of the three peripherals
    assign mapped = (adr_u.fields.slv_idx == SLV_BOOT_MEM) ||
                    (adr_u.fields.slv_idx == SLV_TIMER) ||
                    (adr_u.fields.slv_idx == SLV_IRQ_CTRL);

    ack_err_exclusive: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        !(i_ack && i_err))
        else $error("Decoder raised ack and err in the same cycle");

    ack_after_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_ack |-> $past(i_stb))
        else $error("Decoder ack without a strobe in the previous cycle");

    one_slave_stb: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_stb && mapped) |-> $onehot({i_mem_stb, i_tmr_stb, i_irq_stb}))
        else $error("Mapped access did not raise exactly one slave strobe");

endmodule

/* tests/bus_stimulus.txt */
// op mst we addr data sel exp_data exp_resp (hex, resp 0 ack 1 err)
// op 0 access, 1 start with next record, 2 poll read (data is bound), 3 ext irq, 4 o_irq
// Boot memory byte-lane merges, read back by the other master
0 0 1 00000010 11223344 f 00000000 0
0 0 1 00000010 aabbccdd 5 00000000 0
0 1 0 00000010 00000000 f 11bb33dd 0
0 1 1 00000014 01020304 f 00000000 0
0 1 1 00000014 f0e0d0c0 8 00000000 0
0 0 0 00000014 00000000 f f0020304 0
0 1 1 00000014 99887766 2 00000000 0
0 0 0 00000014 00000000 f f0027704 0
// Both masters in the same cycle
1 0 1 00000320 cafef00d f 00000000 0
1 1 0 00000010 00000000 f 11bb33dd 0
1 0 0 00000320 00000000 f cafef00d 0
1 1 0 00000014 00000000 f f0027704 0
// Unmapped slave indices
0 0 0 30000000 00000000 f 00000000 1
0 1 1 f0000004 12345678 f 00000000 1
// Timer expiry through the interrupt controller
0 0 1 10000000 00000008 f 00000000 0
0 0 0 10000000 00000000 f 00000008 0
0 1 1 10000008 00000001 f 00000000 0
2 0 0 20000004 0000001c f 00000001 0
4 0 0 00000000 00000000 0 00000000 0
0 0 1 20000008 00000001 f 00000000 0
4 0 0 00000000 00000000 0 00000001 0
0 1 0 20000000 00000000 f 00000001 0
0 0 1 10000008 00000000 f 00000000 0
0 0 1 1000000c 00000001 f 00000000 0
4 0 0 00000000 00000000 0 00000000 0
0 1 1 2000000c 00000001 f 00000000 0
// External line 0 on source bit 1
3 0 0 00000000 00000001 0 00000000 0
2 1 0 20000004 00000014 f 00000002 0
4 0 0 00000000 00000000 0 00000000 0
0 0 1 20000008 00000002 f 00000000 0
4 0 0 00000000 00000000 0 00000001 0
0 1 0 20000000 00000000 f 00000002 0
0 0 1 2000000c 00000002 f 00000000 0
4 0 0 00000000 00000000 0 00000000 0
3 0 0 00000000 00000000 0 00000000 0

/* tests/tb_amber_bus.sv */
// Testbench for the two-master bus fabric
// Replays the stimulus file on both master ports, checks read data,
// responses and the processor interrupt
`timescale 1ns/1ps

module tb_amber_bus;

    logic        clk;
    logic        arst_n;
    logic [31:0] m_adr  [2];
    logic [3:0]  m_sel  [2];
    logic        m_we   [2];
    logic [31:0] m_wdat [2];
    logic        m_cyc  [2];
    logic        m_stb  [2];
    logic [31:0] m_rdat [2];
    logic        m_ack  [2];
    logic        m_err  [2];
    logic [1:0]  ext_irq;
    logic        o_irq;

    // Stimulus columns with one entry per record
    logic [31:0] q_op[$];
    logic [31:0] q_mst[$];
    logic [31:0] q_we[$];
    logic [31:0] q_adr[$];
    logic [31:0] q_dat[$];
    logic [31:0] q_sel[$];
    logic [31:0] q_exp[$];
    logic [31:0] q_resp[$];

    int          cycle_cnt = 0;
    int          watchdog_cycles = 0;
    logic [31:0] lfsr_state = 32'h38fd;

    tb_clk_gen u_clk_gen (.o_clk(clk));

    amber_bus_top uut (
        .i_clk    (clk),       .i_arst_n (arst_n),
        .i_m0_adr (m_adr[0]),  .i_m0_sel (m_sel[0]),  .i_m0_we  (m_we[0]),
        .i_m0_dat (m_wdat[0]), .i_m0_cyc (m_cyc[0]),  .i_m0_stb (m_stb[0]),
        .o_m0_dat (m_rdat[0]), .o_m0_ack (m_ack[0]),  .o_m0_err (m_err[0]),
        .i_m1_adr (m_adr[1]),  .i_m1_sel (m_sel[1]),  .i_m1_we  (m_we[1]),
        .i_m1_dat (m_wdat[1]), .i_m1_cyc (m_cyc[1]),  .i_m1_stb (m_stb[1]),
        .o_m1_dat (m_rdat[1]), .o_m1_ack (m_ack[1]),  .o_m1_err (m_err[1]),
        .i_ext_irq (ext_irq),  .o_irq    (o_irq)
    );

    bind wb_slave_decoder amber_bus_props u_props (
        .i_clk (i_clk), .i_arst_n (i_arst_n), .i_adr (i_adr), .i_stb (i_stb),
        .i_ack (o_ack), .i_err (o_err),
        .i_mem_stb (o_mem_stb), .i_tmr_stb (o_tmr_stb), .i_irq_stb (o_irq_stb)
    );

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] galois_next(input logic [31:0] s);
        logic [31:0] n;
        n = {1'b0, s[31:1]};
        if (s[0]) n = n ^ 32'h8020_0003;
        return n;
    endfunction

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    // 1 to 4 idle cycles with one LFSR step per bit
    task automatic idle_gap();
        logic [1:0] g;
        g[0] = lfsr_state[0];
        lfsr_state = galois_next(lfsr_state);
        g[1] = lfsr_state[0];
        lfsr_state = galois_next(lfsr_state);
        repeat (int'(g) + 1) @(posedge clk);
    endtask

    // ----------------------------------------------------------------------
    // One Wishbone access that ends on ack or err seen at a falling edge
    // ----------------------------------------------------------------------
    task automatic bus_access(input logic m, input logic we, input logic [31:0] adr,
                              input logic [31:0] wdat, input logic [3:0] sel,
                              output logic [31:0] rdat, output logic got_err,
                              output int end_cycle);
        @(posedge clk);
        #1;
        m_adr[m]  = adr;
        m_sel[m]  = sel;
        m_we[m]   = we;
        m_wdat[m] = wdat;
        m_cyc[m]  = 1'b1;
        m_stb[m]  = 1'b1;
        do @(negedge clk); while (!(m_ack[m] || m_err[m]));
        rdat      = m_rdat[m];
        got_err   = m_err[m];
        end_cycle = cycle_cnt;
        @(posedge clk);
        #1;
        m_cyc[m] = 1'b0;
        m_stb[m] = 1'b0;
    endtask

    task automatic exec_access(input int k, output int end_cycle);
        logic [31:0] rdat;
        logic        got_err;
        bus_access(q_mst[k][0], q_we[k][0], q_adr[k], q_dat[k], q_sel[k][3:0],
                   rdat, got_err, end_cycle);
        assert (got_err == q_resp[k][0]) else begin
            $display("ERROR o_m%0d_err: expected %0h, got %0h (record %0d)",
                     q_mst[k][0], q_resp[k][0], got_err, k);
            abort_run();
        end
        // Reads check data and unmapped reads return zero
        if (!q_we[k][0]) begin
            assert (rdat == q_exp[k]) else begin
                $display("ERROR o_m%0d_dat: expected %08h, got %08h (record %0d)",
                         q_mst[k][0], q_exp[k], rdat, k);
                abort_run();
            end
        end
    endtask

    // Reads until the expected value shows within the bound in the data column
    task automatic exec_poll(input int k);
        logic [31:0] rdat;
        logic        got_err;
        int          end_cycle;
        int          start;
        start = cycle_cnt;
        do begin
            bus_access(q_mst[k][0], 1'b0, q_adr[k], '0, q_sel[k][3:0],
                       rdat, got_err, end_cycle);
            assert (got_err == q_resp[k][0]) else begin
                $display("ERROR o_m%0d_err: poll of %08h expected %0h, got %0h",
                         q_mst[k][0], q_adr[k], q_resp[k][0], got_err);
                abort_run();
            end
            assert (end_cycle - start <= int'(q_dat[k])) else begin
                $display("ERROR o_m%0d_dat: poll of %08h expected %08h, last %08h",
                         q_mst[k][0], q_adr[k], q_exp[k], rdat);
                abort_run();
            end
        end while (rdat != q_exp[k]);
    endtask

    task automatic load_stimulus();
        int          fd;
        int          code;
        string       line;
        logic [31:0] f [8];
        fd = $fopen("tests/bus_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Stimulus file tests/bus_stimulus.txt could not be opened");
            abort_run();
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0) break;
            if (line.len() < 2 || line.substr(0, 1) == "//") continue;
            code = $sscanf(line, "%h %h %h %h %h %h %h %h",
                           f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (code != 8) begin
                $display("Stimulus line has %0d fields instead of 8: %s", code, line);
                abort_run();
            end
            q_op.push_back(f[0]);
            q_mst.push_back(f[1]);
            q_we.push_back(f[2]);
            q_adr.push_back(f[3]);
            q_dat.push_back(f[4]);
            q_sel.push_back(f[5]);
            q_exp.push_back(f[6]);
            q_resp.push_back(f[7]);
        end
        $fclose(fd);
    endtask

    // Watchdog armed once the record count is known
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Watchdog expired before the stimulus file was finished");
        abort_run();
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        int k;
        int t0;
        int t1;
        arst_n  = 1'b0;
        ext_irq = 2'b00;
        for (int m = 0; m < 2; m++) begin
            m_adr[m]  = '0;
            m_sel[m]  = '0;
            m_we[m]   = 1'b0;
            m_wdat[m] = '0;
            m_cyc[m]  = 1'b0;
            m_stb[m]  = 1'b0;
        end
        load_stimulus();
        watchdog_cycles = q_op.size() * 200 + 110;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        // Quiet outputs after reset
        assert (!m_ack[0] && !m_ack[1] && !m_err[0] && !m_err[1] && !o_irq) else begin
            $display("ERROR reset outputs: ack %h%h err %h%h o_irq %h",
                     m_ack[1], m_ack[0], m_err[1], m_err[0], o_irq);
            abort_run();
        end
        k = 0;
        while (k < q_op.size()) begin
            case (q_op[k])
                0: exec_access(k, t0);
                // Two masters start in the same cycle and master 0 ends first
                1: begin
                    fork
                        exec_access(k, t0);
                        exec_access(k + 1, t1);
                    join
                    assert ((q_mst[k][0] == 1'b0) ? (t0 <= t1) : (t1 <= t0)) else begin
                        $display("Master 1 finished before master 0 on records %0d and %0d",
                                 k, k + 1);
                        abort_run();
                    end
                    k++;
                end
                2: exec_poll(k);
                3: begin
                    @(posedge clk);
                    #1;
                    ext_irq = q_dat[k][1:0];
                end
                4: begin
                    @(negedge clk);
                    assert (o_irq == q_exp[k][0]) else begin
                        $display("ERROR o_irq: expected %0h, got %0h (record %0d)",
                                 q_exp[k][0], o_irq, k);
                        abort_run();
                    end
                end
                default: begin
                    $display("Stimulus record %0d has an unknown operation", k);
                    abort_run();
                end
            endcase
            idle_gap();
            k++;
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* tests/tb_clk_gen.sv */
// Testbench clock source
// Free-running 40 ns clock, starts low
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk
);

    // Half of the 40 ns period
    localparam int HALF_PERIOD = 20;

    initial o_clk = 1'b0;

    always #HALF_PERIOD o_clk = ~o_clk;

endmodule
